/* verilog/hic_pkg.sv */
package hic_pkg;

    // ----------------------------------------
    // Widths with a meaning
    // ----------------------------------------
    typedef logic [31:0] word_t;
    typedef logic [3:0]  sel_t;
    typedef logic [31:0] adr_t;
    // FIFO occupancy as reported in FIFO_STATUS[15:0]
    typedef logic [15:0] fifo_level_t;

    // Frame sequencer states
    typedef enum logic {
        IDLE,
        PUSH
    } frame_state_t;

    // ----------------------------------------
    // Register map, byte addresses
    // ----------------------------------------
    localparam adr_t ADR_ID          = 32'h0000_0000;
    localparam adr_t ADR_VERSION     = 32'h0000_0004;
    localparam adr_t ADR_CTRL        = 32'h0000_0008;
    localparam adr_t ADR_IRQ_EN      = 32'h0000_000C;
    localparam adr_t ADR_STATUS      = 32'h0000_0010;
    localparam adr_t ADR_TIME_NOW    = 32'h0000_0014;
    localparam adr_t ADR_ADC_CMD     = 32'h0000_0020;
    localparam adr_t ADR_FIFO_STATUS = 32'h0000_0024;
    localparam adr_t ADR_FIFO_DATA   = 32'h0000_0028;
    localparam adr_t ADR_SNAP_COUNT  = 32'h0000_002C;
    // Channel c at ADR_RAW_BASE + 4c
    localparam adr_t ADR_RAW_BASE    = 32'h0000_0040;

    // Identity, "HICH"
    localparam word_t CHIP_ID      = 32'h4849_4348;
    localparam word_t CHIP_VERSION = 32'h0000_0001;

    // Base of the stub sample pattern
    localparam word_t RAW_BASE = 32'h0000_1000;

    localparam int IRQ_EN_BITS = 3;

    // ----------------------------------------
    // Internal buses
    // ----------------------------------------
    // Bus beat, valid in the cycle it is accepted
    typedef struct packed {
        logic  fire;
        logic  we;
        adr_t  adr;
        sel_t  sel;
        word_t dat;
    } wb_cmd_t;

    // One-cycle strobes decoded from accepted beats
    typedef struct packed {
        logic snapshot;
        logic ovr_clear;
        logic fifo_pop;
    } wr_strobe_t;

endpackage

/* verilog/hic_wb_front.sv */
`timescale 1ns/1ps
`default_nettype none

module hic_wb_front (
    input  wire                                 wb_clk_i,
    input  wire                                 wb_rst_i,
    input  wire                                 wbs_cyc_i,
    input  wire                                 wbs_stb_i,
    input  wire                                 wbs_we_i,
    input  hic_pkg::sel_t                       wbs_sel_i,
    input  hic_pkg::adr_t                       wbs_adr_i,
    input  hic_pkg::word_t                      wbs_dat_i,
    output logic                                wbs_ack_o,
    output hic_pkg::wb_cmd_t                    cmd_o,
    output hic_pkg::wr_strobe_t                 strobe_o,
    output logic                                ctrl_enable_o,
    output logic                                ctrl_start_o,
    output logic [hic_pkg::IRQ_EN_BITS-1:0]     irq_en_o
);

    logic fire;
    logic wr_fire;
    logic start_req;
    logic start_pending_q;

    // ----------------------------------------
    // Handshake
    // ----------------------------------------
    // One beat accepted per two cycles, ack always in the next cycle
    assign fire    = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;
    assign wr_fire = fire & cmd_o.we;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            wbs_ack_o <= 1'b0;
        end else begin
            wbs_ack_o <= fire;
        end
    end

    // Accepted beat, address forced to a word boundary
    assign cmd_o.fire = fire;
    assign cmd_o.we   = wbs_we_i;
    assign cmd_o.adr  = {wbs_adr_i[31:2], 2'b00};
    assign cmd_o.sel  = wbs_sel_i;
    assign cmd_o.dat  = wbs_dat_i;

    // ----------------------------------------
    // Pulse strobes
    // ----------------------------------------
    // Snapshot on CMD bit 0, lane 0
    assign strobe_o.snapshot = wr_fire && (cmd_o.adr == hic_pkg::ADR_ADC_CMD)
                               && cmd_o.sel[0] && cmd_o.dat[0];
    // Overrun clear on FIFO_STATUS bit 16, lane 2
    assign strobe_o.ovr_clear = wr_fire && (cmd_o.adr == hic_pkg::ADR_FIFO_STATUS)
                                && cmd_o.sel[2] && cmd_o.dat[16];
    // Any read of FIFO_DATA pops
    assign strobe_o.fifo_pop = fire && !cmd_o.we && (cmd_o.adr == hic_pkg::ADR_FIFO_DATA);

    // Start request on CTRL bit 1, lane 0
    assign start_req = wr_fire && (cmd_o.adr == hic_pkg::ADR_CTRL)
                       && cmd_o.sel[0] && cmd_o.dat[1];

    // ----------------------------------------
    // Control registers
    // ----------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            ctrl_enable_o   <= 1'b0;
            irq_en_o        <= '0;
            start_pending_q <= 1'b0;
            ctrl_start_o    <= 1'b0;
        end else begin
            // Start pulse lands the cycle after ack
            start_pending_q <= start_req;
            ctrl_start_o    <= start_pending_q;
            // Enable is sticky, lane 0
            if (wr_fire && (cmd_o.adr == hic_pkg::ADR_CTRL) && cmd_o.sel[0]) begin
                ctrl_enable_o <= cmd_o.dat[0];
            end
            // IRQ_EN lives entirely in lane 0, upper bits dropped
            if (wr_fire && (cmd_o.adr == hic_pkg::ADR_IRQ_EN) && cmd_o.sel[0]) begin
                irq_en_o <= cmd_o.dat[hic_pkg::IRQ_EN_BITS-1:0];
            end
        end
    end

    // Classic single-beat handshake, back-to-back ack would double-accept
    a_ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        wbs_ack_o |=> !wbs_ack_o);

endmodule

`default_nettype wire

/* verilog/hic_snapshot_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module hic_snapshot_seq #(
    parameter int NUM_CH = 8
) (
    input  wire                          wb_clk_i,
    input  wire                          wb_rst_i,
    input  wire                          snapshot_i,
    output hic_pkg::word_t               snap_count_o,
    output hic_pkg::word_t [NUM_CH-1:0]  raw_o,
    output logic                         push_o,
    output hic_pkg::word_t               push_data_o,
    output logic                         frame_drop_o
);

    // Index runs 0 for the status word, then 1..NUM_CH for channels
    localparam int IDX_W = $clog2(NUM_CH + 1);

    hic_pkg::frame_state_t state_q;
    logic [IDX_W-1:0]      idx_q;
    hic_pkg::word_t        frame_base_q;
    hic_pkg::word_t        next_count;
    logic                  frame_start;

    assign next_count  = snap_count_o + 32'h1;
    assign frame_start = snapshot_i && (state_q == hic_pkg::IDLE);

    // ----------------------------------------
    // Snapshot counter and raw channels
    // ----------------------------------------
    // Registers update on every snapshot, busy or not
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            snap_count_o <= '0;
            raw_o        <= '0;
        end else if (snapshot_i) begin
            snap_count_o <= next_count;
            for (int c = 0; c < NUM_CH; c++) begin
                // Stub pattern: base + count + channel
                raw_o[c] <= hic_pkg::RAW_BASE + next_count + hic_pkg::word_t'(c);
            end
        end
    end

    // ----------------------------------------
    // Frame sequencer
    // ----------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state_q <= hic_pkg::IDLE;
            idx_q   <= '0;
        end else begin
            case (state_q)
                hic_pkg::IDLE: begin
                    if (snapshot_i) begin
                        state_q <= hic_pkg::PUSH;
                        idx_q   <= '0;
                    end
                end
                hic_pkg::PUSH: begin
                    // Last channel goes out, then back to idle
                    if (idx_q == IDX_W'(NUM_CH)) begin
                        state_q <= hic_pkg::IDLE;
                    end else begin
                        idx_q <= idx_q + 1'b1;
                    end
                end
                default: state_q <= hic_pkg::IDLE;
            endcase
        end
    end

    // Frame keeps its own base so a later snapshot cannot alter it mid-stream
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            frame_base_q <= '0;
        end else if (frame_start) begin
            frame_base_q <= hic_pkg::RAW_BASE + next_count;
        end
    end

    // One word per cycle, status word first
    assign push_o      = (state_q == hic_pkg::PUSH);
    assign push_data_o = (idx_q == '0) ? '0
                         : frame_base_q + hic_pkg::word_t'(idx_q) - 32'h1;

    // Snapshot while streaming loses its frame
    assign frame_drop_o = snapshot_i && (state_q == hic_pkg::PUSH);

    // A frame is the status word plus one word per channel, never cut short or stretched
    a_frame_len: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        $fell(push_o) |-> $past(push_o, NUM_CH + 1) && !$past(push_o, NUM_CH + 2));

endmodule

`default_nettype wire

/* verilog/hic_sample_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module hic_sample_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire                  wb_clk_i,
    input  wire                  wb_rst_i,
    input  wire                  push_i,
    input  hic_pkg::word_t       push_data_i,
    input  wire                  pop_i,
    input  wire                  ovr_clear_i,
    input  wire                  frame_drop_i,
    output hic_pkg::word_t       head_o,
    output hic_pkg::fifo_level_t level_o,
    output logic                 overrun_o
);

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam hic_pkg::fifo_level_t FULL_LEVEL = hic_pkg::fifo_level_t'(FIFO_DEPTH);

    hic_pkg::word_t mem [FIFO_DEPTH];
    logic [AW-1:0]  wr_ptr_q;
    logic [AW-1:0]  rd_ptr_q;
    logic           full;
    logic           do_push;
    logic           do_pop;

    assign full    = (level_o == FULL_LEVEL);
    // No back-pressure, a push into a full buffer is lost
    assign do_push = push_i && !full;
    assign do_pop  = pop_i && (level_o != '0);

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    // Empty reads as 0
    assign head_o = (level_o == '0) ? '0 : mem[rd_ptr_q];

    // ----------------------------------------
    // Pointers, level and overrun
    // ----------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            level_o   <= '0;
            overrun_o <= 1'b0;
        end else begin
            // Power-of-two depth, pointers wrap on their own
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Push and pop together leave the level alone
            if (do_push && !do_pop) begin
                level_o <= level_o + 1'b1;
            end else if (do_pop && !do_push) begin
                level_o <= level_o - 1'b1;
            end
            // Set wins over a same-cycle clear
            if ((push_i && full) || frame_drop_i) begin
                overrun_o <= 1'b1;
            end else if (ovr_clear_i) begin
                overrun_o <= 1'b0;
            end
        end
    end

    a_level_max: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        level_o <= FULL_LEVEL);

endmodule

`default_nettype wire

/* verilog/hic_read_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module hic_read_mux #(
    parameter int NUM_CH = 8
) (
    input  wire                              wb_clk_i,
    input  wire                              wb_rst_i,
    input  hic_pkg::wb_cmd_t                 cmd_i,
    input  wire [7:0]                        core_status_i,
    input  wire                              ctrl_enable_i,
    input  wire [hic_pkg::IRQ_EN_BITS-1:0]   irq_en_i,
    input  hic_pkg::word_t                   time_now_i,
    input  hic_pkg::word_t                   snap_count_i,
    input  hic_pkg::word_t [NUM_CH-1:0]      raw_i,
    input  hic_pkg::word_t                   fifo_head_i,
    input  hic_pkg::fifo_level_t             fifo_level_i,
    input  wire                              fifo_overrun_i,
    output hic_pkg::word_t                   wbs_dat_o
);

    hic_pkg::word_t rd_word;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    // Reserved bits and unmapped locations read 0
    always_comb begin
        rd_word = '0;
        case (cmd_i.adr)
            hic_pkg::ADR_ID:          rd_word = hic_pkg::CHIP_ID;
            hic_pkg::ADR_VERSION:     rd_word = hic_pkg::CHIP_VERSION;
            // Start bit is write-only
            hic_pkg::ADR_CTRL:        rd_word = hic_pkg::word_t'(ctrl_enable_i);
            hic_pkg::ADR_IRQ_EN:      rd_word = hic_pkg::word_t'(irq_en_i);
            hic_pkg::ADR_STATUS:      rd_word = hic_pkg::word_t'(core_status_i);
            hic_pkg::ADR_TIME_NOW:    rd_word = time_now_i;
            // Command bits are pulses only
            hic_pkg::ADR_ADC_CMD:     rd_word = '0;
            hic_pkg::ADR_FIFO_STATUS: rd_word = {15'h0, fifo_overrun_i, fifo_level_i};
            hic_pkg::ADR_FIFO_DATA:   rd_word = fifo_head_i;
            hic_pkg::ADR_SNAP_COUNT:  rd_word = snap_count_i;
            default: begin
                // Raw channel window
                for (int c = 0; c < NUM_CH; c++) begin
                    if (cmd_i.adr == hic_pkg::ADR_RAW_BASE + hic_pkg::adr_t'(4 * c)) begin
                        rd_word = raw_i[c];
                    end
                end
            end
        endcase
    end

    // ----------------------------------------
    // Data latch
    // ----------------------------------------
    // Captured on every accepted beat, valid alongside ack
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            wbs_dat_o <= '0;
        end else if (cmd_i.fire) begin
            wbs_dat_o <= rd_word;
        end
    end

endmodule

`default_nettype wire

/* verilog/home_inventory_wb.sv */
`timescale 1ns/1ps
`default_nettype none

module home_inventory_wb #(
    parameter int NUM_CH     = 8,
    parameter int FIFO_DEPTH = 16
) (
    input  wire                               wb_clk_i,
    input  wire                               wb_rst_i,
    input  wire                               wbs_cyc_i,
    input  wire                               wbs_stb_i,
    input  wire                               wbs_we_i,
    input  hic_pkg::sel_t                     wbs_sel_i,
    input  hic_pkg::adr_t                     wbs_adr_i,
    input  hic_pkg::word_t                    wbs_dat_i,
    output logic                              wbs_ack_o,
    output hic_pkg::word_t                    wbs_dat_o,
    input  wire [7:0]                         core_status_i,
    output logic                              ctrl_enable_o,
    output logic                              ctrl_start_o,
    output logic [hic_pkg::IRQ_EN_BITS-1:0]   irq_en_o
);

    hic_pkg::wb_cmd_t            cmd;
    hic_pkg::wr_strobe_t         strobe;
    hic_pkg::word_t              time_now_q;
    hic_pkg::word_t              snap_count;
    hic_pkg::word_t [NUM_CH-1:0] raw;
    logic                        push;
    hic_pkg::word_t              push_data;
    logic                        frame_drop;
    hic_pkg::word_t              fifo_head;
    hic_pkg::fifo_level_t        fifo_level;
    logic                        fifo_overrun;

    // Free-running timebase, wraps
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            time_now_q <= '0;
        end else begin
            time_now_q <= time_now_q + 32'h1;
        end
    end

    // ----------------------------------------
    // Bus front end and control
    // ----------------------------------------
    hic_wb_front u_front (
        .wb_clk_i      (wb_clk_i),
        .wb_rst_i      (wb_rst_i),
        .wbs_cyc_i     (wbs_cyc_i),
        .wbs_stb_i     (wbs_stb_i),
        .wbs_we_i      (wbs_we_i),
        .wbs_sel_i     (wbs_sel_i),
        .wbs_adr_i     (wbs_adr_i),
        .wbs_dat_i     (wbs_dat_i),
        .wbs_ack_o     (wbs_ack_o),
        .cmd_o         (cmd),
        .strobe_o      (strobe),
        .ctrl_enable_o (ctrl_enable_o),
        .ctrl_start_o  (ctrl_start_o),
        .irq_en_o      (irq_en_o)
    );

    // Stub ADC snapshot and frame stream
    hic_snapshot_seq #(
        .NUM_CH (NUM_CH)
    ) u_snap (
        .wb_clk_i     (wb_clk_i),
        .wb_rst_i     (wb_rst_i),
        .snapshot_i   (strobe.snapshot),
        .snap_count_o (snap_count),
        .raw_o        (raw),
        .push_o       (push),
        .push_data_o  (push_data),
        .frame_drop_o (frame_drop)
    );

    hic_sample_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .wb_clk_i     (wb_clk_i),
        .wb_rst_i     (wb_rst_i),
        .push_i       (push),
        .push_data_i  (push_data),
        .pop_i        (strobe.fifo_pop),
        .ovr_clear_i  (strobe.ovr_clear),
        .frame_drop_i (frame_drop),
        .head_o       (fifo_head),
        .level_o      (fifo_level),
        .overrun_o    (fifo_overrun)
    );

    // ----------------------------------------
    // Read path
    // ----------------------------------------
    hic_read_mux #(
        .NUM_CH (NUM_CH)
    ) u_rdmux (
        .wb_clk_i       (wb_clk_i),
        .wb_rst_i       (wb_rst_i),
        .cmd_i          (cmd),
        .core_status_i  (core_status_i),
        .ctrl_enable_i  (ctrl_enable_o),
        .irq_en_i       (irq_en_o),
        .time_now_i     (time_now_q),
        .snap_count_i   (snap_count),
        .raw_i          (raw),
        .fifo_head_i    (fifo_head),
        .fifo_level_i   (fifo_level),
        .fifo_overrun_i (fifo_overrun),
        .wbs_dat_o      (wbs_dat_o)
    );

endmodule

`default_nettype wire

/* verif/tb_home_inventory_wb.sv */
`timescale 1ns/1ps

module tb_home_inventory_wb;

    localparam int NUM_CH     = 8;
    localparam int FIFO_DEPTH = 16;
    localparam int ACK_LIMIT  = 8;
    localparam int POLL_LIMIT = 64;

    // Expected identity and stub pattern
    localparam hic_pkg::word_t EXP_ID       = 32'h4849_4348;
    localparam hic_pkg::word_t EXP_VERSION  = 32'h0000_0001;
    localparam hic_pkg::word_t EXP_RAW_BASE = 32'h0000_1000;

    logic                 wb_clk_i;
    logic                 wb_rst_i;
    logic                 wbs_cyc_i;
    logic                 wbs_stb_i;
    logic                 wbs_we_i;
    hic_pkg::sel_t        wbs_sel_i;
    hic_pkg::adr_t        wbs_adr_i;
    hic_pkg::word_t       wbs_dat_i;
    logic                 wbs_ack_o;
    hic_pkg::word_t       wbs_dat_o;
    logic [7:0]           core_status_i;
    logic                 ctrl_enable_o;
    logic                 ctrl_start_o;
    logic [2:0]           irq_en_o;

    integer         seed;
    int             value_errors;
    int             other_errors;
    int             snap_k;
    hic_pkg::word_t rd;
    hic_pkg::word_t t_first;
    hic_pkg::word_t rnd;
    logic [2:0]     irq_exp;

    home_inventory_wb #(
        .NUM_CH     (NUM_CH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_dut (
        .wb_clk_i      (wb_clk_i),
        .wb_rst_i      (wb_rst_i),
        .wbs_cyc_i     (wbs_cyc_i),
        .wbs_stb_i     (wbs_stb_i),
        .wbs_we_i      (wbs_we_i),
        .wbs_sel_i     (wbs_sel_i),
        .wbs_adr_i     (wbs_adr_i),
        .wbs_dat_i     (wbs_dat_i),
        .wbs_ack_o     (wbs_ack_o),
        .wbs_dat_o     (wbs_dat_o),
        .core_status_i (core_status_i),
        .ctrl_enable_o (ctrl_enable_o),
        .ctrl_start_o  (ctrl_start_o),
        .irq_en_o      (irq_en_o)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #5 wb_clk_i = ~wb_clk_i;
    end

    // ----------------------------------------
    // Checks and bus access
    // ----------------------------------------
    task automatic check_word(input string name, input hic_pkg::word_t got,
                              input hic_pkg::word_t exp);
        assert (got === exp) else begin
            value_errors++;
            $display("error %s: expected 0x%08h, got 0x%08h", name, exp, got);
        end
    endtask

    // One beat, driven on the falling edge, ack sampled on the falling edge
    task automatic wb_access(input logic we, input hic_pkg::adr_t adr, input hic_pkg::sel_t sel,
                             input hic_pkg::word_t wdat, output hic_pkg::word_t rdat);
        int waited;
        waited = 0;
        rdat   = '0;
        @(negedge wb_clk_i);
        wbs_cyc_i = 1'b1;
        wbs_stb_i = 1'b1;
        wbs_we_i  = we;
        wbs_adr_i = adr;
        wbs_sel_i = sel;
        wbs_dat_i = wdat;
        do begin
            @(negedge wb_clk_i);
            waited++;
        end while (!wbs_ack_o && waited < ACK_LIMIT);
        assert (wbs_ack_o) else begin
            other_errors++;
            $display("Access to 0x%08h got no ack within %0d cycles", adr, ACK_LIMIT);
        end
        rdat      = wbs_dat_o;
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
    endtask

    task automatic wb_write(input hic_pkg::adr_t adr, input hic_pkg::sel_t sel,
                            input hic_pkg::word_t dat);
        hic_pkg::word_t unused;
        wb_access(1'b1, adr, sel, dat, unused);
    endtask

    task automatic wb_read(input hic_pkg::adr_t adr, output hic_pkg::word_t dat);
        wb_access(1'b0, adr, 4'hF, '0, dat);
    endtask

    task automatic read_check(input string name, input hic_pkg::adr_t adr,
                              input hic_pkg::word_t exp);
        hic_pkg::word_t got;
        wb_read(adr, got);
        check_word({"wbs_dat_o ", name}, got, exp);
    endtask

    // ----------------------------------------
    // Snapshot helpers
    // ----------------------------------------
    task automatic issue_snapshot();
        wb_write(hic_pkg::ADR_ADC_CMD, 4'h1, 32'h1);
        snap_k++;
    endtask

    // Poll FIFO_STATUS until it shows the wanted level and overrun
    task automatic wait_fifo_status(input hic_pkg::word_t want);
        hic_pkg::word_t got;
        int polls;
        polls = 0;
        do begin
            wb_read(hic_pkg::ADR_FIFO_STATUS, got);
            polls++;
        end while (got !== want && polls < POLL_LIMIT);
        assert (got === want) else begin
            other_errors++;
            $display("FIFO status stuck at 0x%08h, never reached 0x%08h", got, want);
        end
    endtask

    task automatic check_snapshot_regs(input int k);
        read_check("SNAP_COUNT", hic_pkg::ADR_SNAP_COUNT, hic_pkg::word_t'(k));
        for (int c = 0; c < NUM_CH; c++) begin
            read_check($sformatf("RAW%0d", c), hic_pkg::ADR_RAW_BASE + hic_pkg::adr_t'(4 * c),
                       EXP_RAW_BASE + hic_pkg::word_t'(k + c));
        end
    endtask

    // Status word 0, then channel values of snapshot k
    task automatic drain_frame(input int k, input int nwords);
        hic_pkg::word_t exp;
        for (int i = 0; i < nwords; i++) begin
            exp = (i == 0) ? '0 : EXP_RAW_BASE + hic_pkg::word_t'(k + i - 1);
            read_check("FIFO_DATA", hic_pkg::ADR_FIFO_DATA, exp);
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        seed          = 32'hd5b3_f538;
        value_errors  = 0;
        other_errors  = 0;
        snap_k        = 0;
        wb_rst_i      = 1'b1;
        wbs_cyc_i     = 1'b0;
        wbs_stb_i     = 1'b0;
        wbs_we_i      = 1'b0;
        wbs_sel_i     = '0;
        wbs_adr_i     = '0;
        wbs_dat_i     = '0;
        core_status_i = '0;
        repeat (2) @(negedge wb_clk_i);
        wb_rst_i = 1'b0;

        // Reset state and identity
        @(negedge wb_clk_i);
        check_word("wbs_ack_o", {31'b0, wbs_ack_o}, 32'h0);
        check_word("ctrl_enable_o", {31'b0, ctrl_enable_o}, 32'h0);
        check_word("ctrl_start_o", {31'b0, ctrl_start_o}, 32'h0);
        check_word("irq_en_o", {29'b0, irq_en_o}, 32'h0);
        read_check("ID", hic_pkg::ADR_ID, EXP_ID);
        read_check("VERSION", hic_pkg::ADR_VERSION, EXP_VERSION);
        wb_read(hic_pkg::ADR_TIME_NOW, t_first);
        wb_read(hic_pkg::ADR_TIME_NOW, rd);
        assert (rd > t_first) else begin
            other_errors++;
            $display("TIME_NOW did not advance, 0x%08h then 0x%08h", t_first, rd);
        end
        rnd           = $random(seed);
        core_status_i = rnd[7:0];
        read_check("STATUS", hic_pkg::ADR_STATUS, {24'b0, rnd[7:0]});

        // Control, sticky enable and IRQ_EN masking
        wb_write(hic_pkg::ADR_CTRL, 4'hF, 32'h1);
        check_word("ctrl_enable_o", {31'b0, ctrl_enable_o}, 32'h1);
        read_check("CTRL", hic_pkg::ADR_CTRL, 32'h1);
        rnd     = $random(seed);
        irq_exp = rnd[2:0];
        wb_write(hic_pkg::ADR_IRQ_EN, 4'hF, rnd);
        read_check("IRQ_EN", hic_pkg::ADR_IRQ_EN, {29'b0, irq_exp});
        check_word("irq_en_o", {29'b0, irq_en_o}, {29'b0, irq_exp});
        // Lane 0 off, nothing changes
        wb_write(hic_pkg::ADR_IRQ_EN, 4'b1110, ~rnd);
        read_check("IRQ_EN", hic_pkg::ADR_IRQ_EN, {29'b0, irq_exp});
        check_word("irq_en_o", {29'b0, irq_en_o}, {29'b0, irq_exp});
        check_word("ctrl_enable_o", {31'b0, ctrl_enable_o}, 32'h1);

        // Start pulse sits in the cycle after ack
        wb_write(hic_pkg::ADR_CTRL, 4'h1, 32'h3);
        check_word("ctrl_start_o", {31'b0, ctrl_start_o}, 32'h0);
        @(negedge wb_clk_i);
        check_word("ctrl_start_o", {31'b0, ctrl_start_o}, 32'h1);
        @(negedge wb_clk_i);
        check_word("ctrl_start_o", {31'b0, ctrl_start_o}, 32'h0);
        read_check("CTRL", hic_pkg::ADR_CTRL, 32'h1);
        wb_write(hic_pkg::ADR_CTRL, 4'hF, 32'h0);
        check_word("ctrl_enable_o", {31'b0, ctrl_enable_o}, 32'h0);

        // Single frames, registers then FIFO contents
        repeat (2) begin
            issue_snapshot();
            wait_fifo_status(32'h0000_0009);
            check_snapshot_regs(snap_k);
            drain_frame(snap_k, NUM_CH + 1);
            read_check("FIFO_STATUS", hic_pkg::ADR_FIFO_STATUS, 32'h0);
            read_check("FIFO_DATA", hic_pkg::ADR_FIFO_DATA, 32'h0);
        end

        // Overrun, second frame cut at seven words
        issue_snapshot();
        wait_fifo_status(32'h0000_0009);
        issue_snapshot();
        wait_fifo_status(32'h0001_0010);
        check_snapshot_regs(snap_k);
        drain_frame(snap_k - 1, NUM_CH + 1);
        drain_frame(snap_k, 7);
        read_check("FIFO_STATUS", hic_pkg::ADR_FIFO_STATUS, 32'h0001_0000);
        wb_write(hic_pkg::ADR_FIFO_STATUS, 4'b1011, 32'hFFFF_FFFF);
        read_check("FIFO_STATUS", hic_pkg::ADR_FIFO_STATUS, 32'h0001_0000);
        wb_write(hic_pkg::ADR_FIFO_STATUS, 4'b0100, 32'h0001_0000);
        read_check("FIFO_STATUS", hic_pkg::ADR_FIFO_STATUS, 32'h0);

        // Back-to-back snapshots, second frame dropped
        issue_snapshot();
        issue_snapshot();
        wait_fifo_status(32'h0001_0009);
        read_check("FIFO_STATUS", hic_pkg::ADR_FIFO_STATUS, 32'h0001_0009);
        check_snapshot_regs(snap_k);
        drain_frame(snap_k - 1, NUM_CH + 1);
        read_check("FIFO_STATUS", hic_pkg::ADR_FIFO_STATUS, 32'h0001_0000);

        $display("Done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
verilog/hic_pkg.sv
verilog/hic_wb_front.sv
verilog/hic_snapshot_seq.sv
verilog/hic_sample_fifo.sv
verilog/hic_read_mux.sv
verilog/home_inventory_wb.sv
verif/tb_home_inventory_wb.sv

/* Makefile */
# Verilator build and run for the home inventory register block
# Override on the command line, e.g. make run TOP=... LOG=...

VERILATOR ?= verilator
TOP       ?= tb_home_inventory_wb
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Pass or fail comes from the log, not the simulator exit code
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^Regression passed$$" $(LOG); then \
		echo "PASS: $(TOP)"; \
	else \
		echo "FAIL: $(TOP), see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
